// File: list.f
hw/nnrv_pkg.sv
hw/nnrv_instr_decoder.sv
hw/nnrv_hazard_unit.sv
hw/nnrv_branch_unit.sv
hw/nnrv_issue_reg.sv
hw/nnrv_decode_stage.sv
tests/nnrv_decode_stage_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= nnrv_decode_stage_tb
FILELIST  ?= list.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and the log"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tests/nnrv_decode_stage_tb.sv
`default_nettype none

module nnrv_decode_stage_tb;

        timeunit 1ns;
        timeprecision 100ps;

        localparam logic [6:0] OPC_IMM = 7'h13, OPC_OP = 7'h33, OPC_LUI = 7'h37;
        localparam logic [6:0] OPC_AUIPC = 7'h17, OPC_JAL = 7'h6f, OPC_BR = 7'h63;
        localparam logic [6:0] OPC_LD = 7'h03, OPC_ST = 7'h23, OPC_FENCE = 7'h0f;
        localparam logic [6:0] OPC_SYS = 7'h73;

        logic                    i_clk;
        logic                    i_rst;
        logic [31:0]             i_if_instr;
        logic [63:0]             i_if_pc;
        logic                    o_if_jmp_stall;
        logic [63:0]             o_if_jmp_pc;
        logic                    o_if_hazard_stall;
        logic [4:0]              o_reg_r1;
        logic [4:0]              o_reg_r2;
        logic [63:0]             i_reg_r1_reg;
        logic [63:0]             i_reg_r2_reg;
        nnrv_pkg::wb_port_t      i_exec_wb;
        nnrv_pkg::wb_port_t      i_mem_wb;
        nnrv_pkg::exec_bus_t     o_exec;

        logic [63:0]             regs [32];
        logic [31:0]             lfsr_state;
        int                      errors;
        int                      checks;
        nnrv_pkg::exec_bus_t     prev_exec;
        nnrv_pkg::jump_t         prev_jump;
        logic                    exp_stall;
        nnrv_pkg::exec_bus_t     exp_exec;
        nnrv_pkg::jump_t         exp_jump;
        logic [31:0]             exp_ins;

        nnrv_decode_stage nnrv_decode_stage_inst (.*);

        // the register file answers in the same cycle and x0 reads as zero.
        assign i_reg_r1_reg = (o_reg_r1 == '0) ? '0 : regs[o_reg_r1];
        assign i_reg_r2_reg = (o_reg_r2 == '0) ? '0 : regs[o_reg_r2];

        initial begin
                i_clk = 1'b0;
                forever #20 i_clk = ~i_clk;
        end

        function automatic logic [31:0] next_bits(input int n);
                logic [31:0] r;
                r = '0;
                for (int k = 0; k < n; k++) begin
                        r = {r[30:0], lfsr_state[0]};
                        lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 :
                                                     lfsr_state >> 1;
                end
                return r;
        endfunction

        function automatic logic [63:0] sx(input logic [63:0] v, input int n);
                logic [63:0] t;
                t = v << (64 - n);
                return $signed(t) >>> (64 - n);
        endfunction

        function automatic logic blocked(input logic [4:0] idx, input logic used);
                if (!used || idx == '0)
                        return 1'b0;
                return (prev_exec.rd_en && prev_exec.rd == idx) ||
                       (i_exec_wb.en && !i_exec_wb.ready && i_exec_wb.rd == idx) ||
                       (i_mem_wb.en && !i_mem_wb.ready && i_mem_wb.rd == idx);
        endfunction

        function automatic logic [63:0] operand(input logic [4:0] idx, input logic used);
                if (used && idx != '0 && i_exec_wb.en && i_exec_wb.ready && i_exec_wb.rd == idx)
                        return i_exec_wb.data;
                if (used && idx != '0 && i_mem_wb.en && i_mem_wb.ready && i_mem_wb.rd == idx)
                        return i_mem_wb.data;
                return (idx == '0) ? '0 : regs[idx];
        endfunction

        function automatic nnrv_pkg::exec_op_e alu(input logic [2:0] f3, input logic alt,
                                                   input logic reg_op);
                case (f3)
                3'd0:    return (alt && reg_op) ? nnrv_pkg::OP_SUB : nnrv_pkg::OP_ADD;
                3'd1:    return nnrv_pkg::OP_SLL;
                3'd2:    return nnrv_pkg::OP_SLT;
                3'd3:    return nnrv_pkg::OP_SLTU;
                3'd4:    return nnrv_pkg::OP_XOR;
                3'd5:    return alt ? nnrv_pkg::OP_SRA : nnrv_pkg::OP_SRL;
                3'd6:    return nnrv_pkg::OP_OR;
                default: return nnrv_pkg::OP_AND;
                endcase
        endfunction

        task automatic reference(output logic stall, output nnrv_pkg::exec_bus_t ex,
                                 output nnrv_pkg::jump_t jp);
                logic [31:0] ins;
                logic [6:0]  opc;
                logic [2:0]  f3;
                logic        u1;
                logic        u2;
                logic        shift;
                logic [63:0] v1;
                logic [63:0] v2;
                logic [7:0]  mask;
                ins   = prev_jump.taken ? nnrv_pkg::NOP_INSTR : i_if_instr;
                opc   = ins[6:0];
                f3    = ins[14:12];
                u1    = opc inside {OPC_IMM, OPC_OP, OPC_BR, OPC_LD, OPC_ST};
                u2    = opc inside {OPC_OP, OPC_BR, OPC_ST};
                stall = blocked(ins[19:15], u1) || blocked(ins[24:20], u2);
                v1    = operand(ins[19:15], u1);
                v2    = operand(ins[24:20], u2);
                shift = (f3 == 3'd1) || (f3 == 3'd5);
                mask  = (8'h01 << (1 << f3[1:0])) - 8'h01;
                ex = '0;
                jp = '0;
                if (!stall) begin
                        ex.pc = i_if_pc;
                        ex.rd = ins[11:7];
                        case (opc)
                        OPC_IMM, OPC_OP: begin
                                ex.op    = alu(f3, ins[30], opc == OPC_OP);
                                ex.rd_en = 1'b1;
                                ex.op1   = v1;
                                if (opc == OPC_OP)
                                        ex.op2 = shift ? {58'b0, v2[5:0]} : v2;
                                else
                                        ex.op2 = shift ? {58'b0, ins[25:20]} :
                                                         sx(64'(ins[31:20]), 12);
                        end
                        OPC_LUI, OPC_AUIPC: begin
                                ex.op    = nnrv_pkg::OP_ADD;
                                ex.rd_en = 1'b1;
                                ex.op1   = (opc == OPC_AUIPC) ? i_if_pc : v1;
                                ex.op2   = sx(64'({ins[31:12], 12'b0}), 32);
                        end
                        OPC_JAL: begin
                                ex.op    = nnrv_pkg::OP_JMP;
                                ex.rd_en = 1'b1;
                                jp.taken = 1'b1;
                                jp.pc    = i_if_pc + sx(64'({ins[31], ins[19:12], ins[20],
                                                             ins[30:21], 1'b0}), 21);
                        end
                        OPC_BR: begin
                                jp.pc = i_if_pc + sx(64'({ins[31], ins[7], ins[30:25],
                                                          ins[11:8], 1'b0}), 13);
                                case (f3)
                                3'd0:    jp.taken = v1 == v2;
                                3'd1:    jp.taken = v1 != v2;
                                3'd4:    jp.taken = $signed(v1) < $signed(v2);
                                3'd5:    jp.taken = $signed(v1) >= $signed(v2);
                                3'd6:    jp.taken = v1 < v2;
                                3'd7:    jp.taken = v1 >= v2;
                                default: jp = '0;
                                endcase
                        end
                        OPC_LD: begin
                                ex.op       = nnrv_pkg::OP_LOAD;
                                ex.rd_en    = 1'b1;
                                ex.op2      = v1 + sx(64'(ins[31:20]), 12);
                                ex.ram_mask = mask;
                                ex.sign     = f3 inside {3'd0, 3'd1, 3'd2};
                        end
                        OPC_ST: begin
                                ex.op       = nnrv_pkg::OP_STORE;
                                ex.op1      = v2;
                                ex.op2      = v1 + sx(64'({ins[31:25], ins[11:7]}), 12);
                                ex.ram_mask = mask;
                        end
                        default: ex = '0;
                        endcase
                end
        endtask

        task automatic drive_random();
                logic [6:0] opc;
                logic [2:0] f3;
                case (next_bits(4) % 10)
                0: opc = OPC_IMM;
                1: opc = OPC_OP;
                2: opc = OPC_LUI;
                3: opc = OPC_AUIPC;
                4: opc = OPC_JAL;
                5: opc = OPC_BR;
                6: opc = OPC_LD;
                7: opc = OPC_ST;
                8: opc = OPC_FENCE;
                default: opc = OPC_SYS;
                endcase
                f3 = 3'(next_bits(3));
                if (opc == OPC_LD && f3 == 3'd7)
                        f3 = 3'd6;
                if (opc == OPC_ST)
                        f3[2] = 1'b0;
                // small register indices make hazards and forwarding frequent.
                i_if_instr = {7'(next_bits(7)), 5'(next_bits(3)), 5'(next_bits(3)),
                              f3, 5'(next_bits(3)), opc};
                i_if_pc    = {32'h0, 30'(next_bits(30)), 2'b00};
                i_exec_wb  = '{en: 1'(next_bits(1)), ready: 1'(next_bits(1)),
                               rd: 5'(next_bits(3)), data: {next_bits(32), next_bits(32)}};
                i_mem_wb   = '{en: 1'(next_bits(1)), ready: 1'(next_bits(1)),
                               rd: 5'(next_bits(3)), data: {next_bits(32), next_bits(32)}};
        endtask

        task automatic check_outputs();
                checks++;
                assert (o_exec == exp_exec) else begin
                        errors++;
                        $display("error t=%0t o_exec expected %h got %h", $time, exp_exec, o_exec);
                end
                assert (o_if_jmp_stall == exp_jump.taken && o_if_jmp_pc == exp_jump.pc) else begin
                        errors++;
                        $display("error t=%0t o_if_jmp_stall/o_if_jmp_pc expected %b/%h got %b/%h",
                                 $time, exp_jump.taken, exp_jump.pc, o_if_jmp_stall, o_if_jmp_pc);
                end
        endtask

        initial begin
                #(40 * 5000);
                $display("timeout: the run did not finish in time");
                $display("Simulation failed");
                $finish;
        end

        initial begin
                int n;
                lfsr_state = 32'd54;
                errors     = 0;
                checks     = 0;
                i_rst      = 1'b1;
                i_if_instr = '0;
                i_if_pc    = '0;
                i_exec_wb  = '0;
                i_mem_wb   = '0;
                for (int r = 0; r < 32; r++)
                        regs[r] = {next_bits(32), next_bits(32)};
                repeat (3) @(posedge i_clk);
                #2 i_rst = 1'b0;
                n = 0;
                while (o_exec !== '0 && n < 10) begin
                        @(posedge i_clk);
                        n++;
                end
                if (o_exec !== '0) begin
                        errors++;
                        $display("o_exec did not clear to a bubble after reset");
                end
                #1;
                prev_exec = '0;
                prev_jump = '0;
                exp_exec  = '0;
                exp_jump  = '0;
                check_outputs();
                assert (o_if_hazard_stall == 1'b0) else begin
                        errors++;
                        $display("error t=%0t o_if_hazard_stall expected 0 got %b",
                                 $time, o_if_hazard_stall);
                end
                @(posedge i_clk);
                #2;
                for (int i = 0; i < 600; i++) begin
                        drive_random();
                        #1;
                        reference(exp_stall, exp_exec, exp_jump);
                        exp_ins = prev_jump.taken ? nnrv_pkg::NOP_INSTR : i_if_instr;
                        assert (o_if_hazard_stall == exp_stall) else begin
                                errors++;
                                $display("error t=%0t o_if_hazard_stall expected %b got %b",
                                         $time, exp_stall, o_if_hazard_stall);
                        end
                        assert (o_reg_r1 == exp_ins[19:15] && o_reg_r2 == exp_ins[24:20]) else begin
                                errors++;
                                $display("error t=%0t o_reg_r1/o_reg_r2 expected %0d/%0d got %0d/%0d",
                                         $time, exp_ins[19:15], exp_ins[24:20],
                                         o_reg_r1, o_reg_r2);
                        end
                        @(posedge i_clk);
                        #1;
                        check_outputs();
                        prev_exec = exp_exec;
                        prev_jump = exp_jump;
                        #1;
                end
                $display("checks %0d errors %0d", checks, errors);
                if (errors == 0)
                        $display("Simulation completed successfully");
                else
                        $display("Simulation failed");
                $finish;
        end

endmodule

`default_nettype wire

// File: hw/nnrv_decode_stage.sv
`default_nettype none

module nnrv_decode_stage (
        input  wire logic                             i_clk,
        input  wire logic                             i_rst,

        input  wire logic [nnrv_pkg::INSTR_WIDTH-1:0] i_if_instr,
        input  wire logic [nnrv_pkg::XLEN-1:0]        i_if_pc,
        output logic                                  o_if_jmp_stall,
        output logic [nnrv_pkg::XLEN-1:0]             o_if_jmp_pc,
        output logic                                  o_if_hazard_stall,

        output logic [nnrv_pkg::REG_IDX_W-1:0]        o_reg_r1,
        output logic [nnrv_pkg::REG_IDX_W-1:0]        o_reg_r2,
        input  wire logic [nnrv_pkg::XLEN-1:0]        i_reg_r1_reg,
        input  wire logic [nnrv_pkg::XLEN-1:0]        i_reg_r2_reg,

        input  wire nnrv_pkg::wb_port_t               i_exec_wb,
        input  wire nnrv_pkg::wb_port_t               i_mem_wb,
        output nnrv_pkg::exec_bus_t                   o_exec
);

        nnrv_pkg::decoded_t          dec;
        nnrv_pkg::jump_t             jump_d;
        nnrv_pkg::jump_t             jump_q;
        logic                        stall;
        logic [nnrv_pkg::XLEN-1:0]   rs1_val;
        logic [nnrv_pkg::XLEN-1:0]   rs2_val;

        assign o_if_jmp_stall    = jump_q.taken;
        assign o_if_jmp_pc       = jump_q.pc;
        assign o_if_hazard_stall = stall;
        assign o_reg_r1          = dec.rs1;
        assign o_reg_r2          = dec.rs2;

        nnrv_instr_decoder nnrv_instr_decoder_inst (
                .i_instr  (i_if_instr),
                .i_squash (jump_q.taken),
                .o_dec    (dec)
        );

        nnrv_hazard_unit nnrv_hazard_unit_inst (
                .i_dec        (dec),
                .i_issued     (o_exec),
                .i_exec_wb    (i_exec_wb),
                .i_mem_wb     (i_mem_wb),
                .i_reg_r1_reg (i_reg_r1_reg),
                .i_reg_r2_reg (i_reg_r2_reg),
                .o_stall      (stall),
                .o_rs1_val    (rs1_val),
                .o_rs2_val    (rs2_val)
        );

        nnrv_branch_unit nnrv_branch_unit_inst (
                .i_dec     (dec),
                .i_pc      (i_if_pc),
                .i_rs1_val (rs1_val),
                .i_rs2_val (rs2_val),
                .o_jump    (jump_d)
        );

        nnrv_issue_reg nnrv_issue_reg_inst (
                .i_clk     (i_clk),
                .i_rst     (i_rst),
                .i_dec     (dec),
                .i_pc      (i_if_pc),
                .i_rs1_val (rs1_val),
                .i_rs2_val (rs2_val),
                .i_stall   (stall),
                .i_jump    (jump_d),
                .o_exec    (o_exec),
                .o_jump    (jump_q)
        );

endmodule

`default_nettype wire

// File: hw/nnrv_issue_reg.sv
`default_nettype none

module nnrv_issue_reg (
        input  wire logic                      i_clk,
        input  wire logic                      i_rst,
        input  wire nnrv_pkg::decoded_t        i_dec,
        input  wire logic [nnrv_pkg::XLEN-1:0] i_pc,
        input  wire logic [nnrv_pkg::XLEN-1:0] i_rs1_val,
        input  wire logic [nnrv_pkg::XLEN-1:0] i_rs2_val,
        input  wire logic                      i_stall,
        input  wire nnrv_pkg::jump_t           i_jump,
        output nnrv_pkg::exec_bus_t            o_exec,
        output nnrv_pkg::jump_t                o_jump
);

        nnrv_pkg::exec_bus_t exec_d;
        nnrv_pkg::alu_f3_e   alu_f3;
        logic                is_shift;

        function automatic nnrv_pkg::exec_op_e alu_op(input nnrv_pkg::alu_f3_e f3,
                                                      input logic alt, input logic reg_op);
                case (f3)
                nnrv_pkg::ADD_SUB: return (alt && reg_op) ? nnrv_pkg::OP_SUB : nnrv_pkg::OP_ADD;
                nnrv_pkg::SLL:     return nnrv_pkg::OP_SLL;
                nnrv_pkg::SLT:     return nnrv_pkg::OP_SLT;
                nnrv_pkg::SLTU:    return nnrv_pkg::OP_SLTU;
                nnrv_pkg::XOR:     return nnrv_pkg::OP_XOR;
                nnrv_pkg::SRL_SRA: return alt ? nnrv_pkg::OP_SRA : nnrv_pkg::OP_SRL;
                nnrv_pkg::OR:      return nnrv_pkg::OP_OR;
                default:           return nnrv_pkg::OP_AND;
                endcase
        endfunction

        // funct3 low bits select the access size for both loads and stores.
        function automatic logic [nnrv_pkg::MASK_WIDTH-1:0] size_mask(input logic [1:0] size);
                case (size)
                2'd0:    return 8'h01;
                2'd1:    return 8'h03;
                2'd2:    return 8'h0f;
                default: return 8'hff;
                endcase
        endfunction

        assign alu_f3   = nnrv_pkg::alu_f3_e'(i_dec.funct3);
        assign is_shift = (alu_f3 == nnrv_pkg::SLL) || (alu_f3 == nnrv_pkg::SRL_SRA);

        always_comb begin
                exec_d = '0;
                if (!i_stall) begin
                        exec_d.pc = i_pc;
                        exec_d.rd = i_dec.rd;
                        case (i_dec.opcode)
                        nnrv_pkg::OP_IMM: begin
                                exec_d.op    = alu_op(alu_f3, i_dec.alt, 1'b0);
                                exec_d.rd_en = 1'b1;
                                exec_d.op1   = i_rs1_val;
                                exec_d.op2   = is_shift ?
                                               {{(nnrv_pkg::XLEN-6){1'b0}}, i_dec.shamt} :
                                               i_dec.imm_i;
                        end
                        nnrv_pkg::OP: begin
                                exec_d.op    = alu_op(alu_f3, i_dec.alt, 1'b1);
                                exec_d.rd_en = 1'b1;
                                exec_d.op1   = i_rs1_val;
                                exec_d.op2   = is_shift ?
                                               {{(nnrv_pkg::XLEN-6){1'b0}}, i_rs2_val[5:0]} :
                                               i_rs2_val;
                        end
                        nnrv_pkg::LUI, nnrv_pkg::AUIPC: begin
                                exec_d.op    = nnrv_pkg::OP_ADD;
                                exec_d.rd_en = 1'b1;
                                exec_d.op1   = (i_dec.opcode == nnrv_pkg::AUIPC) ? i_pc : i_rs1_val;
                                exec_d.op2   = i_dec.imm_u;
                        end
                        nnrv_pkg::JAL: begin
                                exec_d.op    = nnrv_pkg::OP_JMP;
                                exec_d.rd_en = 1'b1;
                        end
                        nnrv_pkg::BRANCH: exec_d.op = nnrv_pkg::OP_NOP;
                        nnrv_pkg::LOAD: begin
                                exec_d.op       = nnrv_pkg::OP_LOAD;
                                exec_d.rd_en    = 1'b1;
                                exec_d.op2      = i_rs1_val + i_dec.imm_i;
                                exec_d.ram_mask = (i_dec.funct3 == 3'b111) ?
                                                  '0 : size_mask(i_dec.funct3[1:0]);
                                // lb, lh and lw extend the sign. ld has nothing to extend.
                                exec_d.sign     = !i_dec.funct3[2] && (i_dec.funct3[1:0] != 2'b11);
                        end
                        nnrv_pkg::STORE: begin
                                exec_d.op       = nnrv_pkg::OP_STORE;
                                exec_d.op1      = i_rs2_val;
                                exec_d.op2      = i_rs1_val + i_dec.imm_s;
                                exec_d.ram_mask = i_dec.funct3[2] ?
                                                  '0 : size_mask(i_dec.funct3[1:0]);
                        end
                        default: exec_d = '0;
                        endcase
                end
        end

        always_ff @(posedge i_clk or posedge i_rst) begin
                if (i_rst) begin
                        o_exec <= '0;
                        o_jump <= '0;
                end else begin
                        o_exec <= exec_d;
                        o_jump <= i_stall ? '0 : i_jump;
                end
        end

endmodule

`default_nettype wire

// File: hw/nnrv_branch_unit.sv
`default_nettype none

module nnrv_branch_unit (
        input  wire nnrv_pkg::decoded_t        i_dec,
        input  wire logic [nnrv_pkg::XLEN-1:0] i_pc,
        input  wire logic [nnrv_pkg::XLEN-1:0] i_rs1_val,
        input  wire logic [nnrv_pkg::XLEN-1:0] i_rs2_val,
        output nnrv_pkg::jump_t                o_jump
);

        always_comb begin
                o_jump = '0;
                case (i_dec.opcode)
                nnrv_pkg::JAL: begin
                        o_jump.taken = 1'b1;
                        o_jump.pc    = i_pc + i_dec.imm_j;
                end
                nnrv_pkg::BRANCH: begin
                        o_jump.pc = i_pc + i_dec.imm_b;
                        case (nnrv_pkg::branch_f3_e'(i_dec.funct3))
                        nnrv_pkg::BEQ:  o_jump.taken = (i_rs1_val == i_rs2_val);
                        nnrv_pkg::BNE:  o_jump.taken = (i_rs1_val != i_rs2_val);
                        nnrv_pkg::BLT:  o_jump.taken = ($signed(i_rs1_val) < $signed(i_rs2_val));
                        nnrv_pkg::BGE:  o_jump.taken = ($signed(i_rs1_val) >= $signed(i_rs2_val));
                        nnrv_pkg::BLTU: o_jump.taken = (i_rs1_val < i_rs2_val);
                        nnrv_pkg::BGEU: o_jump.taken = (i_rs1_val >= i_rs2_val);
                        // funct3 2 and 3 are not branches.
                        default:        o_jump = '0;
                        endcase
                end
                default: o_jump = '0;
                endcase
        end

endmodule

`default_nettype wire

// File: hw/nnrv_hazard_unit.sv
`default_nettype none

module nnrv_hazard_unit (
        input  wire nnrv_pkg::decoded_t        i_dec,
        input  wire nnrv_pkg::exec_bus_t       i_issued,
        input  wire nnrv_pkg::wb_port_t        i_exec_wb,
        input  wire nnrv_pkg::wb_port_t        i_mem_wb,
        input  wire logic [nnrv_pkg::XLEN-1:0] i_reg_r1_reg,
        input  wire logic [nnrv_pkg::XLEN-1:0] i_reg_r2_reg,
        output logic                           o_stall,
        output logic [nnrv_pkg::XLEN-1:0]      o_rs1_val,
        output logic [nnrv_pkg::XLEN-1:0]      o_rs2_val
);

        nnrv_pkg::wb_port_t issued_port;

        function automatic logic hit(input nnrv_pkg::wb_port_t port, input logic used,
                                     input logic [nnrv_pkg::REG_IDX_W-1:0] idx);
                return port.en && used && (idx != '0) && (port.rd == idx);
        endfunction

        function automatic logic waits(input nnrv_pkg::wb_port_t port,
                                       input nnrv_pkg::decoded_t dec);
                return !port.ready && (hit(port, dec.rs1_used, dec.rs1) ||
                                       hit(port, dec.rs2_used, dec.rs2));
        endfunction

        // the nearer stage holds the younger value, so execute wins over memory.
        function automatic logic [nnrv_pkg::XLEN-1:0] fwd(
                input nnrv_pkg::wb_port_t ex, input nnrv_pkg::wb_port_t mem,
                input logic used, input logic [nnrv_pkg::REG_IDX_W-1:0] idx,
                input logic [nnrv_pkg::XLEN-1:0] rf_val);
                if (ex.ready && hit(ex, used, idx))
                        return ex.data;
                if (mem.ready && hit(mem, used, idx))
                        return mem.data;
                return rf_val;
        endfunction

        // the instruction issued last cycle has no result yet in any stage.
        assign issued_port = '{en: i_issued.rd_en, ready: 1'b0, rd: i_issued.rd, data: '0};

        assign o_stall = waits(issued_port, i_dec) || waits(i_exec_wb, i_dec) ||
                         waits(i_mem_wb, i_dec);

        assign o_rs1_val = fwd(i_exec_wb, i_mem_wb, i_dec.rs1_used, i_dec.rs1, i_reg_r1_reg);
        assign o_rs2_val = fwd(i_exec_wb, i_mem_wb, i_dec.rs2_used, i_dec.rs2, i_reg_r2_reg);

endmodule

`default_nettype wire

// File: hw/nnrv_instr_decoder.sv
`default_nettype none

module nnrv_instr_decoder (
        input  wire logic [nnrv_pkg::INSTR_WIDTH-1:0] i_instr,
        input  wire logic                             i_squash,
        output nnrv_pkg::decoded_t                    o_dec
);

        logic [nnrv_pkg::INSTR_WIDTH-1:0] instr;
        logic                             sign;

        // the slot right behind a taken jump was fetched from the old path.
        assign instr = i_squash ? nnrv_pkg::NOP_INSTR : i_instr;
        assign sign  = instr[31];

        always_comb begin
                o_dec.opcode = nnrv_pkg::opcode_e'(instr[6:0]);
                o_dec.funct3 = instr[14:12];
                o_dec.rd     = instr[11:7];
                o_dec.rs1    = instr[19:15];
                o_dec.rs2    = instr[24:20];
                o_dec.alt    = instr[30];
                o_dec.shamt  = instr[25:20];

                o_dec.imm_i = {{(nnrv_pkg::XLEN-12){sign}}, instr[31:20]};
                o_dec.imm_s = {{(nnrv_pkg::XLEN-12){sign}}, instr[31:25], instr[11:7]};
                o_dec.imm_b = {{(nnrv_pkg::XLEN-13){sign}}, instr[31], instr[7],
                               instr[30:25], instr[11:8], 1'b0};
                o_dec.imm_u = {{(nnrv_pkg::XLEN-32){sign}}, instr[31:12], 12'b0};
                o_dec.imm_j = {{(nnrv_pkg::XLEN-21){sign}}, instr[31], instr[19:12],
                               instr[20], instr[30:21], 1'b0};

                case (o_dec.opcode)
                nnrv_pkg::OP, nnrv_pkg::BRANCH, nnrv_pkg::STORE: begin
                        o_dec.rs1_used = 1'b1;
                        o_dec.rs2_used = 1'b1;
                end
                nnrv_pkg::OP_IMM, nnrv_pkg::LOAD: begin
                        o_dec.rs1_used = 1'b1;
                        o_dec.rs2_used = 1'b0;
                end
                default: begin
                        o_dec.rs1_used = 1'b0;
                        o_dec.rs2_used = 1'b0;
                end
                endcase
        end

endmodule

`default_nettype wire

// File: hw/nnrv_pkg.sv
`default_nettype none

package nnrv_pkg;

        localparam int XLEN        = 64;
        localparam int INSTR_WIDTH = 32;
        localparam int MASK_WIDTH  = 8;
        localparam int REG_IDX_W   = 5;

        // addi x0, x0, 0 is the canonical nop.
        localparam logic [INSTR_WIDTH-1:0] NOP_INSTR = 32'h0000_0013;

        typedef enum logic [6:0] {
                OP_IMM   = 7'b0010011,
                LUI      = 7'b0110111,
                AUIPC    = 7'b0010111,
                OP       = 7'b0110011,
                JAL      = 7'b1101111,
                BRANCH   = 7'b1100011,
                LOAD     = 7'b0000011,
                STORE    = 7'b0100011,
                MISC_MEM = 7'b0001111,
                SYSTEM   = 7'b1110011
        } opcode_e;

        // op_nop must stay at zero so that a cleared bundle is a bubble.
        typedef enum logic [3:0] {
                OP_NOP, OP_ADD, OP_SUB, OP_SLT, OP_SLTU,
                OP_XOR, OP_OR, OP_AND, OP_SLL, OP_SRL,
                OP_SRA, OP_JMP, OP_LOAD, OP_STORE
        } exec_op_e;

        typedef enum logic [2:0] {
                ADD_SUB = 3'b000,
                SLL     = 3'b001,
                SLT     = 3'b010,
                SLTU    = 3'b011,
                XOR     = 3'b100,
                SRL_SRA = 3'b101,
                OR      = 3'b110,
                AND     = 3'b111
        } alu_f3_e;

        typedef enum logic [2:0] {
                BEQ  = 3'b000,
                BNE  = 3'b001,
                BLT  = 3'b100,
                BGE  = 3'b101,
                BLTU = 3'b110,
                BGEU = 3'b111
        } branch_f3_e;

        typedef struct packed {
                opcode_e              opcode;
                logic [2:0]           funct3;
                logic [REG_IDX_W-1:0] rd;
                logic [REG_IDX_W-1:0] rs1;
                logic [REG_IDX_W-1:0] rs2;
                logic                 alt;
                logic [5:0]           shamt;
                logic [XLEN-1:0]      imm_i;
                logic [XLEN-1:0]      imm_s;
                logic [XLEN-1:0]      imm_b;
                logic [XLEN-1:0]      imm_u;
                logic [XLEN-1:0]      imm_j;
                logic                 rs1_used;
                logic                 rs2_used;
        } decoded_t;

        typedef struct packed {
                logic                 en;
                logic                 ready;
                logic [REG_IDX_W-1:0] rd;
                logic [XLEN-1:0]      data;
        } wb_port_t;

        typedef struct packed {
                logic [XLEN-1:0]       pc;
                logic [XLEN-1:0]       op1;
                logic [XLEN-1:0]       op2;
                exec_op_e              op;
                logic                  rd_en;
                logic [REG_IDX_W-1:0]  rd;
                logic [MASK_WIDTH-1:0] ram_mask;
                logic                  sign;
        } exec_bus_t;

        typedef struct packed {
                logic            taken;
                logic [XLEN-1:0] pc;
        } jump_t;

endpackage

`default_nettype wire
